// File: noncomp_slice.f
source/fp_fmt_pkg.sv
source/noncomp_pkg.sv
source/lane_dispatch.sv
source/noncomp_op.sv
source/lane_pipe.sv
source/result_pack.sv
source/noncomp_slice.sv
+incdir+verif
verif/tb_noncomp_slice.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the slice testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_noncomp_slice -f noncomp_slice.f \
  -Mdir obj_dir -o tb_noncomp_slice || { echo "Build error"; exit 1; }
./obj_dir/tb_noncomp_slice > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation OK"
exit 0

// File: source/fp_fmt_pkg.sv
/* Supported floating-point formats of the slice. Only FP32 and FP16 exist,
   so the format enum is a single bit */
package fp_fmt_pkg;

  // --------------------------------------------------
  // Formats
  // --------------------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_format_e;

  // Total widths
  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;

  // Exponent field sizes
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP16_EXP_BITS = 5;

  // Mantissa field sizes, MSB of the field is the quiet bit
  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_MAN_BITS = 10;

  // --------------------------------------------------
  // Canonical quiet NaNs
  // --------------------------------------------------
  localparam logic [FP32_WIDTH-1:0] FP32_CANON_NAN = 32'h7FC0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_CANON_NAN = 16'h7E00;

endpackage

// File: source/lane_dispatch.sv
/* Input side of the slice. Only FP16 runs vectorial, an FP32 operation
   marked vectorial is executed as scalar on lane 0 */
module lane_dispatch
  import fp_fmt_pkg::*;
  import noncomp_pkg::*;
(
  input  logic [NUM_OPERANDS-1:0][DATA_WIDTH-1:0] operands_i,
  input  fp_format_e                              src_fmt_i,
  input  logic                                    vectorial_op_i,
  input  logic [NUM_LANES-1:0]                    simd_mask_i,
  input  logic                                    in_valid_i,
  output logic [NUM_LANES-1:0]                    lane_valid_o,
  output logic [NUM_LANES-1:0][DATA_WIDTH-1:0]    lane_a_o,
  output logic [NUM_LANES-1:0][DATA_WIDTH-1:0]    lane_b_o,
  output logic [NUM_LANES-1:0]                    lane_mask_o,
  output logic [AUX_WIDTH-1:0]                    aux_o
);

  logic vec_fp16;  // Effective vectorial flag

  assign vec_fp16 = vectorial_op_i & (src_fmt_i == FMT_FP16);

  // --------------------------------------------------
  // Operand slicing and lane valids
  // --------------------------------------------------
  always_comb begin : slice_operands
    int unsigned fmt_width;

    fmt_width = (src_fmt_i == FMT_FP32) ? FP32_WIDTH : FP16_WIDTH;

    for (int unsigned lane = 0; lane < NUM_LANES; lane++) begin
      // Upper bits of each slice are ignored by the lane
      lane_a_o[lane] = operands_i[0] >> (lane * fmt_width);
      lane_b_o[lane] = operands_i[1] >> (lane * fmt_width);

      // Upper lanes only run for vectorial FP16
      if (lane == 0) begin
        lane_valid_o[lane] = in_valid_i;
      end else begin
        lane_valid_o[lane] = in_valid_i & vec_fp16;
      end
    end
  end

  assign lane_mask_o = simd_mask_i;  // One mask bit per lane

  // --------------------------------------------------
  // Aux data
  // --------------------------------------------------
  // Format and vectorial flag travel with the result for packing
  always_comb begin : build_aux
    aux_o              = '0;
    aux_o[AUX_FMT_BIT] = logic'(src_fmt_i);
    aux_o[AUX_VEC_BIT] = vec_fp16;
  end

endmodule

// File: source/lane_pipe.sv
/* One register stage per lane. Holds at most one item; a new item enters
   in the cycle the held one leaves. flush_i drops the held item */
module lane_pipe
  import noncomp_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Upstream side
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic                    flush_i,
  input  logic [DATA_WIDTH-1:0]   result_i,
  input  logic [STATUS_WIDTH-1:0] status_i,
  input  logic                    mask_i,
  input  logic [AUX_WIDTH-1:0]    aux_i,
  input  logic [TAG_WIDTH-1:0]    tag_i,
  // Downstream side
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic [DATA_WIDTH-1:0]   result_o,
  output logic [STATUS_WIDTH-1:0] status_o,
  output logic                    mask_o,
  output logic [AUX_WIDTH-1:0]    aux_o,
  output logic [TAG_WIDTH-1:0]    tag_o
);

  logic valid_q;
  logic load;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  assign in_ready_o  = out_ready_i | ~valid_q;  // Empty or draining
  assign load        = in_valid_i & in_ready_o;
  assign out_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------
  // Enable register, stays put under back-pressure
  always_ff @(posedge clk_i) begin : payload_reg
    if (load) begin
      result_o <= result_i;
      status_o <= status_i;
      mask_o   <= mask_i;
      aux_o    <= aux_i;
      tag_o    <= tag_i;
    end
  end

endmodule

// File: source/noncomp_op.sv
/* Sign injection and min/max for one lane, combinational. Operands are
   assumed properly NaN-boxed; upper bits of an FP16 result are don't care */
module noncomp_op
  import fp_fmt_pkg::*;
  import noncomp_pkg::*;
#(
  parameter bit Fp32Enable = 1'b1  // 0 gives an FP16-only lane
) (
  input  logic [DATA_WIDTH-1:0]   a_i,
  input  logic [DATA_WIDTH-1:0]   b_i,
  input  noncomp_op_e             op_i,
  input  fp_format_e              fmt_i,
  output logic [DATA_WIDTH-1:0]   result_o,
  output logic [STATUS_WIDTH-1:0] status_o
);

  logic [DATA_WIDTH-1:0]   opnd [NUM_OPERANDS];
  logic [DATA_WIDTH-2:0]   mag  [NUM_OPERANDS];
  logic [NUM_OPERANDS-1:0] sgn, is_nan, is_snan;
  logic                    use_fp32;
  logic                    a_lt_b;

  assign opnd[0] = a_i;
  assign opnd[1] = b_i;

  // FP32 decoding only exists in lanes that can hold FP32
  if (Fp32Enable) begin : gen_fp32
    assign use_fp32 = (fmt_i == FMT_FP32);
  end else begin : gen_fp16_only
    assign use_fp32 = 1'b0;
  end

  // --------------------------------------------------
  // Operand classification
  // --------------------------------------------------
  always_comb begin : classify
    for (int i = 0; i < NUM_OPERANDS; i++) begin
      mag[i] = '0;
      if (use_fp32) begin
        sgn[i]     = opnd[i][FP32_WIDTH-1];
        mag[i]     = opnd[i][FP32_WIDTH-2:0];
        is_nan[i]  = (&opnd[i][FP32_WIDTH-2 -: FP32_EXP_BITS]) &
                     (|opnd[i][FP32_MAN_BITS-1:0]);
        is_snan[i] = is_nan[i] & ~opnd[i][FP32_MAN_BITS-1];
      end else begin
        sgn[i]                    = opnd[i][FP16_WIDTH-1];
        mag[i][FP16_WIDTH-2:0]    = opnd[i][FP16_WIDTH-2:0];
        is_nan[i]  = (&opnd[i][FP16_WIDTH-2 -: FP16_EXP_BITS]) &
                     (|opnd[i][FP16_MAN_BITS-1:0]);
        is_snan[i] = is_nan[i] & ~opnd[i][FP16_MAN_BITS-1];
      end
    end
  end

  // Sign-magnitude ordering, -0 counts as less than +0
  always_comb begin : compare
    if (sgn[0] != sgn[1]) begin
      a_lt_b = sgn[0];
    end else if (sgn[0]) begin
      a_lt_b = (mag[0] > mag[1]);  // Both negative
    end else begin
      a_lt_b = (mag[0] < mag[1]);
    end
  end

  // --------------------------------------------------
  // Operation
  // --------------------------------------------------
  always_comb begin : operate
    int unsigned sign_pos;

    sign_pos = use_fp32 ? FP32_WIDTH - 1 : FP16_WIDTH - 1;
    result_o = a_i;
    status_o = '0;

    unique case (op_i)
      OP_SGNJ:  result_o[sign_pos] = sgn[1];
      OP_SGNJN: result_o[sign_pos] = ~sgn[1];
      OP_SGNJX: result_o[sign_pos] = sgn[0] ^ sgn[1];
      OP_FMIN, OP_FMAX: begin
        status_o[STATUS_NV] = |is_snan;
        if (&is_nan) begin
          result_o = use_fp32 ? FP32_CANON_NAN :
                     {{(DATA_WIDTH-FP16_WIDTH){1'b1}}, FP16_CANON_NAN};
        end else if (is_nan[0]) begin
          result_o = b_i;
        end else if (is_nan[1]) begin
          result_o = a_i;
        end else begin
          result_o = (a_lt_b ^ (op_i == OP_FMAX)) ? a_i : b_i;
        end
      end
      default: result_o = a_i;  // Unused encodings pass a through
    endcase
  end

endmodule

// File: source/noncomp_pkg.sv
/* Operation set and datapath layout of the non-computational slice.
   Status flags follow the RISC-V fflags order NV DZ OF UF NX */
package noncomp_pkg;

  // --------------------------------------------------
  // Operations
  // --------------------------------------------------
  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,  // Sign of b
    OP_SGNJN = 3'd1,  // Inverted sign of b
    OP_SGNJX = 3'd2,  // Sign of a XOR sign of b
    OP_FMIN  = 3'd3,
    OP_FMAX  = 3'd4
  } noncomp_op_e;

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  localparam int unsigned DATA_WIDTH   = 32;
  localparam int unsigned NUM_LANES    = 2;
  localparam int unsigned NUM_OPERANDS = 2;
  localparam int unsigned TAG_WIDTH    = 4;

  // Status vector, NV sits in the MSB
  localparam int unsigned STATUS_WIDTH = 5;
  localparam int unsigned STATUS_NV    = 4;

  // Aux data sent along with each lane item
  localparam int unsigned AUX_WIDTH   = 2;
  localparam int unsigned AUX_FMT_BIT = 1;  // fp_format_e of the result
  localparam int unsigned AUX_VEC_BIT = 0;  // Lane 1 carries a result

endpackage

// File: source/noncomp_slice.sv
/* Two-lane SIMD slice for sign injection and min/max, one cycle latency.
   FP32 uses lane 0 only; vectorial FP16 uses both lanes */
module noncomp_slice
  import fp_fmt_pkg::*;
  import noncomp_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  // Operation
  input  logic [NUM_OPERANDS-1:0][DATA_WIDTH-1:0] operands_i,
  input  noncomp_op_e                             op_i,
  input  fp_format_e                              src_fmt_i,
  input  logic                                    vectorial_op_i,
  input  logic [NUM_LANES-1:0]                    simd_mask_i,
  input  logic [TAG_WIDTH-1:0]                    tag_i,
  // Input handshake
  input  logic                                    in_valid_i,
  output logic                                    in_ready_o,
  input  logic                                    flush_i,
  // Result
  output logic [DATA_WIDTH-1:0]                   result_o,
  output logic [STATUS_WIDTH-1:0]                 status_o,
  output logic                                    extension_bit_o,
  output logic [TAG_WIDTH-1:0]                    tag_o,
  // Output handshake
  output logic                                    out_valid_o,
  input  logic                                    out_ready_i,
  output logic                                    busy_o
);

  logic [NUM_LANES-1:0]                   lane_valid, lane_mask, lane_ready;
  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]   lane_a, lane_b, op_result, pipe_result;
  logic [NUM_LANES-1:0][STATUS_WIDTH-1:0] op_status, pipe_status;
  logic [NUM_LANES-1:0]                   pipe_valid, pipe_mask;
  logic [NUM_LANES-1:0][AUX_WIDTH-1:0]    pipe_aux;   // Lane 0 is used
  logic [NUM_LANES-1:0][TAG_WIDTH-1:0]    pipe_tag;   // Lane 0 is used
  logic [AUX_WIDTH-1:0]                   aux_data;

  // --------------------------------------------------
  // Input side
  // --------------------------------------------------
  lane_dispatch u_dispatch (
    .operands_i     ( operands_i     ),
    .src_fmt_i      ( src_fmt_i      ),
    .vectorial_op_i ( vectorial_op_i ),
    .simd_mask_i    ( simd_mask_i    ),
    .in_valid_i     ( in_valid_i     ),
    .lane_valid_o   ( lane_valid     ),
    .lane_a_o       ( lane_a         ),
    .lane_b_o       ( lane_b         ),
    .lane_mask_o    ( lane_mask      ),
    .aux_o          ( aux_data       )
  );

  assign in_ready_o = lane_ready[0];  // Upstream ready from first lane

  // --------------------------------------------------
  // Lanes
  // --------------------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    noncomp_op #(
      .Fp32Enable ( lane == 0 )  // Upper lanes are FP16 only
    ) u_op (
      .a_i      ( lane_a[lane]    ),
      .b_i      ( lane_b[lane]    ),
      .op_i     ( op_i            ),
      .fmt_i    ( src_fmt_i       ),
      .result_o ( op_result[lane] ),
      .status_o ( op_status[lane] )
    );

    lane_pipe u_pipe (
      .clk_i       ( clk_i             ),
      .arst_n_i    ( arst_n_i          ),
      .in_valid_i  ( lane_valid[lane]  ),
      .in_ready_o  ( lane_ready[lane]  ),
      .flush_i     ( flush_i           ),
      .result_i    ( op_result[lane]   ),
      .status_i    ( op_status[lane]   ),
      .mask_i      ( lane_mask[lane]   ),
      .aux_i       ( aux_data          ),
      .tag_i       ( tag_i             ),
      .out_valid_o ( pipe_valid[lane]  ),
      .out_ready_i ( out_ready_i       ),
      .result_o    ( pipe_result[lane] ),
      .status_o    ( pipe_status[lane] ),
      .mask_o      ( pipe_mask[lane]   ),
      .aux_o       ( pipe_aux[lane]    ),
      .tag_o       ( pipe_tag[lane]    )
    );
  end

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  result_pack u_pack (
    .lane0_valid_i   ( pipe_valid[0]   ),
    .lane1_valid_i   ( pipe_valid[1]   ),
    .lane0_result_i  ( pipe_result[0]  ),
    .lane1_result_i  ( pipe_result[1]  ),
    .lane0_status_i  ( pipe_status[0]  ),
    .lane1_status_i  ( pipe_status[1]  ),
    .lane_mask_i     ( pipe_mask       ),
    .aux_i           ( pipe_aux[0]     ),
    .result_o        ( result_o        ),
    .status_o        ( status_o        ),
    .extension_bit_o ( extension_bit_o )
  );

  assign tag_o       = pipe_tag[0];
  assign out_valid_o = pipe_valid[0];
  assign busy_o      = |pipe_valid;

endmodule

// File: source/result_pack.sv
/* Output side of the slice. Lane 0 aux decides the format and whether
   lane 1 contributes; narrow results are NaN-boxed with ones */
module result_pack
  import fp_fmt_pkg::*;
  import noncomp_pkg::*;
(
  input  logic                    lane0_valid_i,
  input  logic                    lane1_valid_i,
  input  logic [DATA_WIDTH-1:0]   lane0_result_i,
  input  logic [DATA_WIDTH-1:0]   lane1_result_i,
  input  logic [STATUS_WIDTH-1:0] lane0_status_i,
  input  logic [STATUS_WIDTH-1:0] lane1_status_i,
  input  logic [NUM_LANES-1:0]    lane_mask_i,
  input  logic [AUX_WIDTH-1:0]    aux_i,
  output logic [DATA_WIDTH-1:0]   result_o,
  output logic [STATUS_WIDTH-1:0] status_o,
  output logic                    extension_bit_o
);

  fp_format_e res_fmt;
  logic       lane1_used;

  assign res_fmt    = fp_format_e'(aux_i[AUX_FMT_BIT]);
  assign lane1_used = lane1_valid_i & aux_i[AUX_VEC_BIT];

  assign extension_bit_o = 1'b1;  // NaN-boxing

  // --------------------------------------------------
  // Result packing
  // --------------------------------------------------
  always_comb begin : pack_result
    if (res_fmt == FMT_FP32) begin
      result_o = lane0_result_i[FP32_WIDTH-1:0];
    end else if (lane1_used) begin
      result_o = {lane1_result_i[FP16_WIDTH-1:0], lane0_result_i[FP16_WIDTH-1:0]};
    end else begin
      // Scalar FP16, box the upper half
      result_o = {{(DATA_WIDTH-FP16_WIDTH){1'b1}}, lane0_result_i[FP16_WIDTH-1:0]};
    end
  end

  // Masked-off lanes raise no flags
  always_comb begin : collapse_status
    status_o = '0;
    if (lane0_valid_i) begin
      status_o = status_o | (lane0_status_i & {STATUS_WIDTH{lane_mask_i[0]}});
    end
    if (lane1_used) begin
      status_o = status_o | (lane1_status_i & {STATUS_WIDTH{lane_mask_i[1]}});
    end
  end

endmodule

// File: verif/tb_vectors.svh
/* Stimulus table with results worked out by hand from the FP rules.
   Scalar FP16 operands are NaN-boxed; vectorial FP16 packs lane 1 on top */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

  // Each row gives op, format, vectorial, mask, operand a, operand b, tag, result and status
  task automatic load_vectors();
    // --------------------------------------------------
    // FP32 on lane 0
    // --------------------------------------------------
    add_row(OP_SGNJ,  FMT_FP32, 1'b0, 2'b01, 32'h3F800000, 32'hC0000000, 4'h0, 32'hBF800000, 5'h00);
    add_row(OP_SGNJN, FMT_FP32, 1'b0, 2'b01, 32'h3F800000, 32'hC0000000, 4'h1, 32'h3F800000, 5'h00);
    add_row(OP_SGNJX, FMT_FP32, 1'b0, 2'b01, 32'hBF800000, 32'hC0000000, 4'h2, 32'h3F800000, 5'h00);
    add_row(OP_FMIN,  FMT_FP32, 1'b0, 2'b01, 32'h00000000, 32'h80000000, 4'h3, 32'h80000000, 5'h00);
    add_row(OP_FMAX,  FMT_FP32, 1'b0, 2'b01, 32'h00000000, 32'h80000000, 4'h4, 32'h00000000, 5'h00);
    add_row(OP_FMIN,  FMT_FP32, 1'b0, 2'b01, 32'h40400000, 32'hC0A00000, 4'h5, 32'hC0A00000, 5'h00);
    add_row(OP_FMAX,  FMT_FP32, 1'b0, 2'b01, 32'hC0400000, 32'hC0A00000, 4'h6, 32'hC0400000, 5'h00);
    add_row(OP_FMIN,  FMT_FP32, 1'b0, 2'b01, 32'h7FC00000, 32'h3F800000, 4'h7, 32'h3F800000, 5'h00);
    add_row(OP_FMAX,  FMT_FP32, 1'b0, 2'b01, 32'h7FC00001, 32'h7FC12345, 4'h8, 32'h7FC00000, 5'h00);
    add_row(OP_FMIN,  FMT_FP32, 1'b0, 2'b01, 32'h7F800001, 32'h3F800000, 4'h9, 32'h3F800000, 5'h10);

    // FP16 scalar with the upper half boxed with ones
    add_row(OP_SGNJN, FMT_FP16, 1'b0, 2'b01, 32'hFFFF3C00, 32'hFFFF3C00, 4'hA, 32'hFFFFBC00, 5'h00);
    add_row(OP_FMIN,  FMT_FP16, 1'b0, 2'b01, 32'hFFFF4200, 32'hFFFFC500, 4'hB, 32'hFFFFC500, 5'h00);
    add_row(OP_FMAX,  FMT_FP16, 1'b0, 2'b01, 32'hFFFF7D00, 32'hFFFF4000, 4'hC, 32'hFFFF4000, 5'h10);
    add_row(OP_FMAX,  FMT_FP16, 1'b0, 2'b01, 32'hFFFF7E01, 32'hFFFF7C01, 4'hD, 32'hFFFF7E00, 5'h10);

    // --------------------------------------------------
    // FP16 vectorial, both lanes
    // --------------------------------------------------
    add_row(OP_SGNJX, FMT_FP16, 1'b1, 2'b11, 32'hBC003C00, 32'hC000C000, 4'hE, 32'h3C00BC00, 5'h00);
    add_row(OP_FMIN,  FMT_FP16, 1'b1, 2'b11, 32'h80004000, 32'h00003C00, 4'hF, 32'h80003C00, 5'h00);
    add_row(OP_FMAX,  FMT_FP16, 1'b1, 2'b01, 32'h7D003C00, 32'h40004200, 4'h0, 32'h40004200, 5'h00);
    add_row(OP_FMAX,  FMT_FP16, 1'b1, 2'b11, 32'h7D003C00, 32'h40004200, 4'h1, 32'h40004200, 5'h10);
    add_row(OP_FMIN,  FMT_FP16, 1'b1, 2'b10, 32'h3C007C01, 32'h40003C00, 4'h2, 32'h3C003C00, 5'h00);

    // FP32 marked vectorial runs as scalar
    add_row(OP_SGNJ,  FMT_FP32, 1'b1, 2'b11, 32'h3F800000, 32'h80000000, 4'h3, 32'hBF800000, 5'h00);
  endtask

`endif

// File: verif/tb_noncomp_slice.sv
/* Testbench for the noncomp slice. Runs the table directly, again under random
   back-pressure, then flushes a held item; stops at the first mismatch */
module tb_noncomp_slice
  import fp_fmt_pkg::*;
  import noncomp_pkg::*;
();

  localparam int WAIT_LIMIT  = 50;   // Cycles per input handshake
  localparam int DRAIN_LIMIT = 500;  // Cycles for the whole random replay

  typedef struct packed {
    noncomp_op_e             op;
    fp_format_e              fmt;
    logic                    vec;
    logic [NUM_LANES-1:0]    mask;
    logic [DATA_WIDTH-1:0]   a;
    logic [DATA_WIDTH-1:0]   b;
    logic [TAG_WIDTH-1:0]    tag;
    logic [DATA_WIDTH-1:0]   exp_result;
    logic [STATUS_WIDTH-1:0] exp_status;
  } row_t;

  logic                                    clk, arst_n;
  logic [NUM_OPERANDS-1:0][DATA_WIDTH-1:0] operands;
  noncomp_op_e                             op;
  fp_format_e                              src_fmt;
  logic                                    vectorial_op, in_valid, flush, out_ready;
  logic [NUM_LANES-1:0]                    simd_mask;
  logic [TAG_WIDTH-1:0]                    tag_in, tag_out;
  logic                                    in_ready, ext_bit, out_valid, busy;
  logic [DATA_WIDTH-1:0]                   result;
  logic [STATUS_WIDTH-1:0]                 status;

  row_t vectors[$];
  int   seed = 32'h58bc_0e52;

  always #50 clk = ~clk;

  noncomp_slice u_dut (
    .clk_i           ( clk          ),
    .arst_n_i        ( arst_n       ),
    .operands_i      ( operands     ),
    .op_i            ( op           ),
    .src_fmt_i       ( src_fmt      ),
    .vectorial_op_i  ( vectorial_op ),
    .simd_mask_i     ( simd_mask    ),
    .tag_i           ( tag_in       ),
    .in_valid_i      ( in_valid     ),
    .in_ready_o      ( in_ready     ),
    .flush_i         ( flush        ),
    .result_o        ( result       ),
    .status_o        ( status       ),
    .extension_bit_o ( ext_bit      ),
    .tag_o           ( tag_out      ),
    .out_valid_o     ( out_valid    ),
    .out_ready_i     ( out_ready    ),
    .busy_o          ( busy         )
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic add_row(input noncomp_op_e r_op, input fp_format_e r_fmt, input logic r_vec,
                         input logic [NUM_LANES-1:0] r_mask, input logic [DATA_WIDTH-1:0] r_a,
                         input logic [DATA_WIDTH-1:0] r_b, input logic [TAG_WIDTH-1:0] r_tag,
                         input logic [DATA_WIDTH-1:0] r_res,
                         input logic [STATUS_WIDTH-1:0] r_status);
    row_t r;
    r.op         = r_op;
    r.fmt        = r_fmt;
    r.vec        = r_vec;
    r.mask       = r_mask;
    r.a          = r_a;
    r.b          = r_b;
    r.tag        = r_tag;
    r.exp_result = r_res;
    r.exp_status = r_status;
    vectors.push_back(r);
  endtask

  `include "tb_vectors.svh"

  task automatic drive_row(input row_t r);
    operands[0]  = r.a;
    operands[1]  = r.b;
    op           = r.op;
    src_fmt      = r.fmt;
    vectorial_op = r.vec;
    simd_mask    = r.mask;
    tag_in       = r.tag;
    in_valid     = 1'b1;
  endtask

  // Returns at the rising edge that takes the driven item
  task automatic wait_accept(output int stalls);
    stalls = 0;
    @(posedge clk);
    while (!in_ready) begin
      stalls++;
      assert (stalls < WAIT_LIMIT) else stop_on_error("Timeout: the slice never accepted input");
      @(posedge clk);
    end
  endtask

  task automatic check_output(input row_t r);
    assert (out_valid === 1'b1)
      else stop_on_error($sformatf("FAIL %0t: no result for tag %0h", $time, r.tag));
    assert (result === r.exp_result)
      else stop_on_error($sformatf("FAIL %0t: result %h, expected %h (tag %0h)",
                                   $time, result, r.exp_result, r.tag));
    assert (status === r.exp_status)
      else stop_on_error($sformatf("FAIL %0t: status %b, expected %b (tag %0h)",
                                   $time, status, r.exp_status, r.tag));
    assert (tag_out === r.tag)
      else stop_on_error($sformatf("FAIL %0t: tag %0h, expected %0h", $time, tag_out, r.tag));
    assert (ext_bit === 1'b1)
      else stop_on_error($sformatf("FAIL %0t: extension bit low", $time));
  endtask

  initial begin : main
    int                      stalls;
    int                      received;
    int                      rnd;
    logic                    held;
    logic [DATA_WIDTH-1:0]   held_result;
    logic [STATUS_WIDTH-1:0] held_status;
    logic [TAG_WIDTH-1:0]    held_tag;

    clk          = 1'b0;
    arst_n       = 1'b0;
    operands     = '0;
    op           = OP_SGNJ;
    src_fmt      = FMT_FP32;
    vectorial_op = 1'b0;
    simd_mask    = '0;
    tag_in       = '0;
    in_valid     = 1'b0;
    flush        = 1'b0;
    out_ready    = 1'b1;
    load_vectors();

    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid && !busy && in_ready)
      else stop_on_error("Slice not idle and ready after reset");

    // --------------------------------------------------
    // Directed pass, one item per cycle
    // --------------------------------------------------
    for (int i = 0; i < vectors.size(); i++) begin
      drive_row(vectors[i]);
      wait_accept(stalls);
      assert (stalls == 0) else stop_on_error("Input stalled while out_ready was high");
      if (i == 0) begin
        // Output stays empty until the accepting edge
        assert (!out_valid) else stop_on_error("Result valid before the first input was taken");
      end
      @(negedge clk);
      check_output(vectors[i]);  // One cycle after acceptance
    end
    in_valid = 1'b0;
    @(negedge clk);
    assert (!out_valid && !busy) else stop_on_error("Slice did not drain after the table");

    // --------------------------------------------------
    // Replay with random back-pressure
    // --------------------------------------------------
    received = 0;
    held     = 1'b0;
    fork
      begin : producer
        for (int i = 0; i < vectors.size(); i++) begin
          drive_row(vectors[i]);
          wait_accept(stalls);
          @(negedge clk);
        end
        in_valid = 1'b0;
      end
      begin : consumer
        int cycles;
        cycles = 0;
        while (received < vectors.size()) begin
          @(posedge clk);
          cycles++;
          assert (cycles < DRAIN_LIMIT) else stop_on_error("Timeout: results missing in replay");
          if (out_valid) begin
            if (held) begin
              assert (result === held_result && status === held_status && tag_out === held_tag)
                else stop_on_error($sformatf("FAIL %0t: held output changed", $time));
            end
            if (out_ready) begin
              check_output(vectors[received]);  // Table order
              received++;
              held = 1'b0;
            end else begin
              held        = 1'b1;
              held_result = result;
              held_status = status;
              held_tag    = tag_out;
            end
          end
          @(negedge clk);
          rnd       = $random(seed);
          out_ready = rnd[0];
        end
      end
    join
    out_ready = 1'b1;
    @(negedge clk);

    // --------------------------------------------------
    // Flush of an item held under back-pressure
    // --------------------------------------------------
    out_ready = 1'b0;
    drive_row(vectors[17]);
    wait_accept(stalls);
    @(negedge clk);
    in_valid = 1'b0;
    assert (out_valid && busy && !in_ready) else stop_on_error("Item not held under back-pressure");
    held_result = result;
    @(negedge clk);
    assert (result === held_result)
      else stop_on_error($sformatf("FAIL %0t: held result changed before flush", $time));
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    assert (!out_valid && !busy && in_ready) else stop_on_error("Flush did not empty the slice");
    out_ready = 1'b1;
    repeat (3) begin
      @(posedge clk);
      assert (!out_valid) else stop_on_error("Flushed item came out of the slice");
    end

    $display("Testbench passed");
    $finish;
  end

endmodule
